// File: design/mem_hier_pkg.sv
package mem_hier_pkg;

  // --------------------------------------------------------------------------
  // topology
  // --------------------------------------------------------------------------

  localparam int NUM_CACHES      = 4;
  localparam int NUM_CHANNELS    = 2;
  localparam int CACHES_PER_CHAN = NUM_CACHES / NUM_CHANNELS;

  // --------------------------------------------------------------------------
  // address fields
  // --------------------------------------------------------------------------

  // byte within a 32-bit word
  localparam int BYTE_OFFSET_W = 2;
  // word within a 16-word block
  localparam int WORD_OFFSET_W = 4;
  // block index inside one channel
  localparam int INDEX_W       = 11;
  // bank bit selecting a cache within its channel
  localparam int LOCAL_BANK_W  = 1;
  // channel number plus local bank
  localparam int BANK_W        = 2;
  localparam int BLOCK_INDEX_W = BANK_W + INDEX_W;

  localparam int CACHE_ADDR_W  = LOCAL_BANK_W + INDEX_W + WORD_OFFSET_W + BYTE_OFFSET_W;
  localparam int MEM_ADDR_W    = 24;
  localparam int DATA_W        = 32;

  // fold the low index bits into the bank field
  localparam int IHASH_ENABLE  = 1;

  // --------------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------------

  typedef logic [CACHE_ADDR_W-1:0]  cache_addr_t;
  typedef logic [MEM_ADDR_W-1:0]    mem_addr_t;
  typedef logic [BANK_W-1:0]        bank_id_t;
  typedef logic [BLOCK_INDEX_W-1:0] block_index_t;
  typedef logic [DATA_W-1:0]        data_t;

  // request as issued by a cache bank
  typedef struct packed {
    logic        write;
    cache_addr_t addr;
    data_t       data;
  } dma_req_t;

  // request on a memory channel port
  typedef struct packed {
    logic      write;
    mem_addr_t addr;
    data_t     data;
  } mem_req_t;

endpackage

// File: design/req_capture.sv
`timescale 1ns/10ps

module req_capture (
  input  logic                                                 clk_i
  ,input  logic                                                rst_i
  // cache side
  ,input  logic [mem_hier_pkg::NUM_CACHES-1:0]                 req_v_i
  ,input  mem_hier_pkg::dma_req_t [mem_hier_pkg::NUM_CACHES-1:0] req_i
  ,output logic [mem_hier_pkg::NUM_CACHES-1:0]                 req_yumi_o
  // channel side
  ,input  logic [mem_hier_pkg::NUM_CACHES-1:0]                 slot_pop_i
  ,output logic [mem_hier_pkg::NUM_CACHES-1:0]                 slot_v_o
  ,output mem_hier_pkg::dma_req_t [mem_hier_pkg::NUM_CACHES-1:0] slot_req_o
);

  import mem_hier_pkg::*;

  logic     [NUM_CACHES-1:0] slot_v_q;
  dma_req_t [NUM_CACHES-1:0] slot_req_q;
  logic     [NUM_CACHES-1:0] take;

  // a request is taken only into an empty slot
  assign take       = req_v_i & ~slot_v_q;
  assign req_yumi_o = take;

  // --------------------------------------------------------------------------
  // slot occupancy
  // --------------------------------------------------------------------------

  // fill and pop never meet on one slot since a full slot refuses requests
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_v_q <= '0;
    end else begin
      for (int k = 0; k < NUM_CACHES; k++) begin
        if (take[k]) begin
          slot_v_q[k] <= 1'b1;
        end else if (slot_pop_i[k]) begin
          slot_v_q[k] <= 1'b0;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // slot payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NUM_CACHES; k++) begin
      if (take[k]) begin
        slot_req_q[k] <= req_i[k];
      end
    end
  end

  assign slot_v_o   = slot_v_q;
  assign slot_req_o = slot_req_q;

endmodule

// File: design/channel_remap.sv
`timescale 1ns/10ps

module channel_remap #(
  parameter int CHAN_ID = 0
) (
  input  logic                                                      clk_i
  ,input  logic                                                     rst_i
  // slots of the two caches on this channel
  ,input  logic [mem_hier_pkg::CACHES_PER_CHAN-1:0]                 slot_v_i
  ,input  mem_hier_pkg::dma_req_t [mem_hier_pkg::CACHES_PER_CHAN-1:0] slot_req_i
  ,output logic [mem_hier_pkg::CACHES_PER_CHAN-1:0]                 slot_pop_o
  // memory port
  ,input  logic                                                     mem_ready_i
  ,output logic                                                     mem_v_o
  ,output mem_hier_pkg::mem_req_t                                   mem_req_o
);

  import mem_hier_pkg::*;

  logic                     last_grant_q;
  logic                     sel;
  logic                     any_v;
  logic                     can_accept;
  logic                     pop;
  dma_req_t                 pick;

  logic [BYTE_OFFSET_W-1:0] byte_off;
  logic [WORD_OFFSET_W-1:0] word_off;
  logic [INDEX_W-1:0]       index;
  logic [LOCAL_BANK_W-1:0]  local_bank;
  bank_id_t                 global_bank;
  bank_id_t                 bank_field;
  block_index_t             block_index;
  mem_req_t                 remap;

  logic                     mem_v_q;
  mem_req_t                 mem_req_q;

  // --------------------------------------------------------------------------
  // round-robin pick between the two slots
  // --------------------------------------------------------------------------

  assign any_v      = |slot_v_i;
  // output register empty or drained on this edge
  assign can_accept = ~mem_v_q | mem_ready_i;
  assign pop        = any_v & can_accept;

  // with both waiting the one not served last wins
  always_comb begin
    if (&slot_v_i) begin
      sel = ~last_grant_q;
    end else begin
      sel = slot_v_i[1];
    end
  end

  always_comb begin
    slot_pop_o      = '0;
    slot_pop_o[sel] = pop;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_grant_q <= 1'b0;
    end else if (pop) begin
      last_grant_q <= sel;
    end
  end

  // --------------------------------------------------------------------------
  // address remap
  // --------------------------------------------------------------------------

  // cache side:  | local bank | index | word offset | byte offset |
  // memory side: | zeros | bank field | index | word offset | byte offset |

  assign pick = slot_req_i[sel];

  always_comb begin
    {local_bank, index, word_off, byte_off} = pick.addr;

    // channel number sits above the local bank bit
    global_bank = {CHAN_ID[BANK_W-LOCAL_BANK_W-1:0], local_bank};

    if (IHASH_ENABLE != 0) begin
      bank_field = global_bank ^ index[BANK_W-1:0];
    end else begin
      bank_field = global_bank;
    end

    block_index = {bank_field, index};

    remap.write = pick.write;
    remap.addr  = {
      {(MEM_ADDR_W-BLOCK_INDEX_W-WORD_OFFSET_W-BYTE_OFFSET_W){1'b0}},
      block_index,
      word_off,
      byte_off
    };
    remap.data  = pick.data;
  end

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------

  // holds while stalled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_v_q <= 1'b0;
    end else if (can_accept) begin
      mem_v_q <= any_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      mem_req_q <= remap;
    end
  end

  assign mem_v_o   = mem_v_q;
  assign mem_req_o = mem_req_q;

endmodule

// File: design/mem_hier_top.sv
`timescale 1ns/10ps

module mem_hier_top (
  input  logic                                                 clk_i
  ,input  logic                                                rst_i
  // cache banks
  ,input  logic [mem_hier_pkg::NUM_CACHES-1:0]                 req_v_i
  ,input  mem_hier_pkg::dma_req_t [mem_hier_pkg::NUM_CACHES-1:0] req_i
  ,output logic [mem_hier_pkg::NUM_CACHES-1:0]                 req_yumi_o
  // memory channels
  ,output logic [mem_hier_pkg::NUM_CHANNELS-1:0]               mem_v_o
  ,output mem_hier_pkg::mem_req_t [mem_hier_pkg::NUM_CHANNELS-1:0] mem_req_o
  ,input  logic [mem_hier_pkg::NUM_CHANNELS-1:0]               mem_ready_i
);

  import mem_hier_pkg::*;

  logic     [NUM_CACHES-1:0] slot_v_lo;
  dma_req_t [NUM_CACHES-1:0] slot_req_lo;
  logic     [NUM_CACHES-1:0] slot_pop_li;

  // one slot per cache bank
  req_capture i_req_capture (
    .clk_i       (clk_i)
    ,.rst_i      (rst_i)
    ,.req_v_i    (req_v_i)
    ,.req_i      (req_i)
    ,.req_yumi_o (req_yumi_o)
    ,.slot_pop_i (slot_pop_li)
    ,.slot_v_o   (slot_v_lo)
    ,.slot_req_o (slot_req_lo)
  );

  // --------------------------------------------------------------------------
  // memory channels
  // --------------------------------------------------------------------------

  // channel c serves slots 2c and 2c+1
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    channel_remap #(
      .CHAN_ID(c)
    ) i_channel_remap (
      .clk_i        (clk_i)
      ,.rst_i       (rst_i)
      ,.slot_v_i    (slot_v_lo[c*CACHES_PER_CHAN +: CACHES_PER_CHAN])
      ,.slot_req_i  (slot_req_lo[c*CACHES_PER_CHAN +: CACHES_PER_CHAN])
      ,.slot_pop_o  (slot_pop_li[c*CACHES_PER_CHAN +: CACHES_PER_CHAN])
      ,.mem_ready_i (mem_ready_i[c])
      ,.mem_v_o     (mem_v_o[c])
      ,.mem_req_o   (mem_req_o[c])
    );
  end

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD_NS    = 8
  ,parameter int RESET_CYCLES = 3
) (
  output logic clk_o
  ,output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge like the other stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: tests/mem_hier_props.sv
`timescale 1ns/10ps

module mem_hier_props (
  input  logic                                                     clk_i
  ,input logic                                                     rst_i
  ,input logic [mem_hier_pkg::NUM_CHANNELS-1:0]                    mem_v_i
  ,input mem_hier_pkg::mem_req_t [mem_hier_pkg::NUM_CHANNELS-1:0]   mem_req_i
  ,input logic [mem_hier_pkg::NUM_CHANNELS-1:0]                    mem_ready_i
);

  import mem_hier_pkg::*;

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    // a stalled request holds until memory takes it
    stall_hold_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (mem_v_i[c] && !mem_ready_i[c]) |=> (mem_v_i[c] && $stable(mem_req_i[c]))
    ) else $error("channel %0d: memory request changed while stalled", c);

    // no request leaves while in reset
    reset_idle_a : assert property (
      @(posedge clk_i) rst_i |=> !mem_v_i[c]
    ) else $error("channel %0d: mem_v_o high after a reset edge", c);
  end

endmodule

bind mem_hier_top mem_hier_props i_mem_hier_props (
  .clk_i        (clk_i)
  ,.rst_i       (rst_i)
  ,.mem_v_i     (mem_v_o)
  ,.mem_req_i   (mem_req_o)
  ,.mem_ready_i (mem_ready_i)
);

// File: tests/mem_hier_tb.sv
`timescale 1ns/10ps

module mem_hier_tb;

  import mem_hier_pkg::*;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 3;
  localparam int IDLE_CYCLES   = 20;
  localparam int RANDOM_CYCLES = 2000;
  localparam int DRAIN_CYCLES  = 100;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS   = 4 * TOTAL_CYCLES * CLK_PERIOD_NS;

  logic                        clk;
  logic                        rst;
  logic     [NUM_CACHES-1:0]   req_v;
  dma_req_t [NUM_CACHES-1:0]   req;
  logic     [NUM_CACHES-1:0]   req_yumi;
  logic     [NUM_CHANNELS-1:0] mem_v;
  mem_req_t [NUM_CHANNELS-1:0] mem_req;
  logic     [NUM_CHANNELS-1:0] mem_ready;

  integer                      seed;
  int                          errors;
  int                          checks;
  logic     [NUM_CACHES-1:0]   holding;
  int                          accepted [NUM_CACHES];
  int                          transferred [NUM_CACHES];
  // expected memory-side requests, oldest first
  mem_req_t                    exp_q [NUM_CACHES][$];

  clock_gen #(
    .PERIOD_NS     (CLK_PERIOD_NS)
    ,.RESET_CYCLES (RESET_CYCLES)
  ) i_clock_gen (
    .clk_o  (clk)
    ,.rst_o (rst)
  );

  mem_hier_top i_mem_hier_top (
    .clk_i        (clk)
    ,.rst_i       (rst)
    ,.req_v_i     (req_v)
    ,.req_i       (req)
    ,.req_yumi_o  (req_yumi)
    ,.mem_v_o     (mem_v)
    ,.mem_req_o   (mem_req)
    ,.mem_ready_i (mem_ready)
  );

  // --------------------------------------------------------------------------
  // reference model and checks
  // --------------------------------------------------------------------------

  // field positions counted from bit 0 of the cache address
  function automatic mem_req_t remap_ref(input dma_req_t r, input int chan);
    mem_req_t res;
    int       a;
    int       byte_off;
    int       word_off;
    int       index;
    int       bank;
    a        = int'(r.addr);
    byte_off = a & ((1 << BYTE_OFFSET_W) - 1);
    word_off = (a >> BYTE_OFFSET_W) & ((1 << WORD_OFFSET_W) - 1);
    index    = (a >> (BYTE_OFFSET_W + WORD_OFFSET_W)) & ((1 << INDEX_W) - 1);
    bank     = (chan << LOCAL_BANK_W) | ((a >> (BYTE_OFFSET_W + WORD_OFFSET_W + INDEX_W)) & 1);
    if (IHASH_ENABLE != 0) begin
      bank = bank ^ (index & ((1 << BANK_W) - 1));
    end
    a = (bank << (INDEX_W + WORD_OFFSET_W + BYTE_OFFSET_W))
        | (index << (WORD_OFFSET_W + BYTE_OFFSET_W))
        | (word_off << BYTE_OFFSET_W) | byte_off;
    res.write = r.write;
    res.addr  = mem_addr_t'(a);
    res.data  = r.data;
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, errors - errs_before);
  endtask

  // sampled on the rising edge before the DUT registers update
  task automatic observe_edge(input bit expect_idle);
    mem_req_t got;
    int       hit;
    int       k;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (expect_idle) begin
        check_value($sformatf("mem_v_o[%0d]", c), 64'(mem_v[c]), 64'(0));
      end
      if (mem_v[c] && mem_ready[c]) begin
        got = mem_req[c];
        hit = -1;
        // only the heads of this channel's own caches are candidates
        for (int j = CACHES_PER_CHAN - 1; j >= 0; j--) begin
          k = c * CACHES_PER_CHAN + j;
          if (exp_q[k].size() > 0 && exp_q[k][0] === got) begin
            hit = k;
          end
        end
        if (hit >= 0) begin
          checks++;
          exp_q[hit].delete(0);
          transferred[hit]++;
        end else begin
          k = c * CACHES_PER_CHAN;
          if (exp_q[k].size() == 0) begin
            k++;
          end
          if (exp_q[k].size() == 0) begin
            report_failure($sformatf("channel %0d sent a request no cache issued", c));
          end else begin
            check_value($sformatf("mem_req_o[%0d]", c), 64'(got), 64'(exp_q[k][0]));
            exp_q[k].delete(0);
            transferred[k]++;
          end
        end
      end
    end
    for (k = 0; k < NUM_CACHES; k++) begin
      if (req_v[k] && req_yumi[k]) begin
        exp_q[k].push_back(remap_ref(req[k], k / CACHES_PER_CHAN));
        accepted[k]++;
        holding[k] = 1'b0;
        // one in the slot plus one in the output register at most
        if (accepted[k] - transferred[k] > 2) begin
          report_failure($sformatf("cache %0d got yumi while its slot was still full", k));
        end
      end else if (!req_v[k]) begin
        check_value($sformatf("req_yumi_o[%0d]", k), 64'(req_yumi[k]), 64'(0));
      end
    end
  endtask

  // a cache holds its request until yumi
  task automatic drive_inputs(input bit issue_en, input bit ready_rand);
    int unsigned r;
    for (int k = 0; k < NUM_CACHES; k++) begin
      if (!holding[k]) begin
        req_v[k] = 1'b0;
        if (issue_en && 1'($random(seed))) begin
          req_v[k]       = 1'b1;
          req[k].write   = 1'($random(seed));
          req[k].addr    = cache_addr_t'($random(seed));
          req[k].data    = data_t'($random(seed));
          holding[k]     = 1'b1;
        end
      end
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      r            = $random(seed);
      mem_ready[c] = ready_rand ? ((r % 10) < 7) : 1'b1;
    end
  endtask

  task automatic run_cycle(input bit issue_en, input bit ready_rand, input bit expect_idle);
    @(posedge clk);
    observe_edge(expect_idle);
    @(negedge clk);
    drive_inputs(issue_en, ready_rand);
  endtask

  function automatic bit all_drained();
    bit done;
    done = (holding == '0) && (mem_v == '0);
    for (int k = 0; k < NUM_CACHES; k++) begin
      done = done && (exp_q[k].size() == 0);
    end
    return done;
  endfunction

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    int errs_before;
    int drain_count;
    seed      = 32'hc434bcfa;
    errors    = 0;
    checks    = 0;
    holding   = '0;
    req_v     = '0;
    req       = '0;
    mem_ready = '0;
    for (int k = 0; k < NUM_CACHES; k++) begin
      accepted[k]    = 0;
      transferred[k] = 0;
    end
    wait (rst == 1'b0);

    errs_before = errors;
    repeat (IDLE_CYCLES) run_cycle(1'b0, 1'b1, 1'b1);
    report_test("idle_after_reset", errs_before);

    errs_before = errors;
    repeat (RANDOM_CYCLES) run_cycle(1'b1, 1'b1, 1'b0);
    report_test("random_traffic", errs_before);

    // no new requests and memory always ready
    errs_before = errors;
    drain_count = 0;
    while (!all_drained() && drain_count < DRAIN_CYCLES) begin
      run_cycle(1'b0, 1'b0, 1'b0);
      drain_count++;
    end
    for (int k = 0; k < NUM_CACHES; k++) begin
      if (exp_q[k].size() != 0) begin
        report_failure($sformatf("cache %0d: %0d requests never reached memory",
                                 k, exp_q[k].size()));
      end
      if (holding[k]) begin
        report_failure($sformatf("cache %0d: request was never accepted", k));
      end
    end
    report_test("final_drain", errs_before);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, the tests did not complete", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: mem_hier.f
design/mem_hier_pkg.sv
design/req_capture.sv
design/channel_remap.sv
design/mem_hier_top.sv
tests/clock_gen.sv
tests/mem_hier_props.sv
tests/mem_hier_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f mem_hier.f --top-module mem_hier_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vmem_hier_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass line only when every check passed
if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
